//--- Makefile
TOOL       ?= verilator
TOP        ?= flowMuxLruStableTb
FILELIST   ?= src.f
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
BUILD_DIR  ?= obj_dir
SIM_BIN    ?= VflowMuxSim
LOG        ?= sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/arbCtrlPkg.sv
// Control types only; flowVec_t width follows FLOW_COUNT from flowMux_macros.svh
`include "flowMux_macros.svh"

package arbCtrlPkg;

  // ------------------------------
  // Per-flow vectors
  // ------------------------------

  // One bit per flow, used for requests, grants and readies
  typedef logic [`FLOW_COUNT-1:0] flowVec_t;

  // Pairwise recency matrix of the LRU arbiter
  // Row i, column j set means flow i was used less recently than flow j
  typedef logic [`FLOW_COUNT-1:0][`FLOW_COUNT-1:0] recencyMatrix_t;

  // ------------------------------
  // Skid buffer fill state
  // ------------------------------

  // Number of beats held in a two-entry ingress buffer
  typedef enum logic [1:0] {
    slotEmpty = 2'd0,
    slotOne   = 2'd1,
    slotTwo   = 2'd2
  } slotState_t;

  // Reset order of the arbiter, lower flow numbers are older
  function automatic recencyMatrix_t resetRecency();
    recencyMatrix_t m;
    m = '0;
    for (int i = 0; i < `FLOW_COUNT; i++) begin
      for (int j = i + 1; j < `FLOW_COUNT; j++) begin
        m[i][j] = 1'b1;
      end
    end
    return m;
  endfunction

endpackage

//--- design/flowDataPkg.sv
// Datapath types only; sizes follow flowMux_macros.svh and change with it
`include "flowMux_macros.svh"

package flowDataPkg;

  // ------------------------------
  // Beat types
  // ------------------------------

  // One payload beat as pushed by a producer
  typedef logic [`DATA_WIDTH-1:0] flowBeat_t;

  // Flow number carried with each popped beat
  typedef logic [`FLOW_ID_WIDTH-1:0] flowId_t;

  // Tagged beat held in the output register
  // Source flow sits in the upper bits, payload below
  typedef struct packed {
    flowId_t   flowId;
    flowBeat_t data;
  } popBeat_t;

  // ------------------------------
  // Helpers
  // ------------------------------

  // Build a tagged beat from payload and flow number
  function automatic popBeat_t makePopBeat(flowBeat_t data, flowId_t flowId);
    popBeat_t beat;
    beat.flowId = flowId;
    beat.data   = data;
    return beat;
  endfunction

endpackage

//--- design/flowIngress.sv
// headTaken must only pulse while request is high; pushReady is registered and drops at two beats
`timescale 1ns/1ps
`include "flowMux_macros.svh"

module flowIngress (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pushValid,
  output logic                  pushReady,
  input  flowDataPkg::flowBeat_t pushData,
  input  logic                  headTaken,
  output logic                  request,
  output flowDataPkg::flowBeat_t headBeat
);

  import flowDataPkg::*;
  import arbCtrlPkg::*;

  // ------------------------------
  // Storage and fill state
  // ------------------------------

  slotState_t state;
  slotState_t stateNext;
  // Head beat seen by the arbiter
  flowBeat_t  slotZero;
  // Skid entry that fills while the head stalls
  flowBeat_t  slotSkid;
  logic       pushFire;

  assign pushFire = pushValid & pushReady;

  // Head beat and request always come from slot zero
  assign request  = (state != slotEmpty);
  assign headBeat = slotZero;

  // Next fill level from push and take in this cycle
  always_comb begin
    stateNext = state;
    case (state)
      slotEmpty: if (pushFire) stateNext = slotOne;
      slotOne: begin
        if (pushFire && !headTaken) stateNext = slotTwo;
        else if (!pushFire && headTaken) stateNext = slotEmpty;
      end
      // Ready is low here, so only a take can happen
      slotTwo: if (headTaken) stateNext = slotOne;
      default: stateNext = slotEmpty;
    endcase
  end

  // Fill state and a ready registered from the next fill level
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= slotEmpty;
      pushReady <= 1'b1;
    end else begin
      state     <= stateNext;
      pushReady <= (stateNext != slotTwo);
    end
  end

  // Payload slots
  always_ff @(posedge clk) begin
    if (state == slotTwo) begin
      // Skid entry moves up when the head leaves
      if (headTaken) slotZero <= slotSkid;
    end else if (pushFire) begin
      // New beat becomes the head when the buffer is empty or the head leaves
      if (state == slotEmpty || headTaken) slotZero <= pushData;
      else slotSkid <= pushData;
    end
  end

endmodule

//--- design/flowMuxCore.sv
// Output register holds popBeat until popReady; headTaken and grantAccepted pulse only on a load
`timescale 1ns/1ps
`include "flowMux_macros.svh"

module flowMuxCore (
  input  logic                                      clk,
  input  logic                                      reset,
  input  arbCtrlPkg::flowVec_t                      grant,
  input  flowDataPkg::flowBeat_t [`FLOW_COUNT-1:0]  headBeat,
  output arbCtrlPkg::flowVec_t                      headTaken,
  output logic                                      grantAccepted,
  input  logic                                      popReady,
  output logic                                      popValid,
  output flowDataPkg::popBeat_t                     popBeat
);

  import flowDataPkg::*;
  import arbCtrlPkg::*;

  // ------------------------------
  // Grant-driven mux
  // ------------------------------

  flowBeat_t muxData;
  flowId_t   muxId;
  logic      anyGrant;
  logic      regFree;
  logic      loadEn;

  // AND-OR mux, grant is one-hot or zero
  always_comb begin
    muxData = '0;
    muxId   = '0;
    for (int i = 0; i < `FLOW_COUNT; i++) begin
      if (grant[i]) begin
        muxData = muxData | headBeat[i];
        muxId   = muxId | `FLOW_ID_WIDTH'(i);
      end
    end
  end

  assign anyGrant = |grant;

  // ------------------------------
  // Load control
  // ------------------------------

  // Register has room when empty or drained by this cycle's pop
  assign regFree = !popValid || popReady;
  assign loadEn  = regFree && anyGrant;

  // Strobes only on a load, so a stalled pop freezes everything
  assign grantAccepted = loadEn;
  assign headTaken     = loadEn ? grant : '0;

  // ------------------------------
  // Stable output register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      popValid <= 1'b0;
    end else if (loadEn) begin
      popValid <= 1'b1;
    end else if (popReady) begin
      popValid <= 1'b0;
    end
  end

  // Payload holds while popValid is high and popReady is low
  always_ff @(posedge clk) begin
    if (loadEn) begin
      popBeat <= makePopBeat(muxData, muxId);
    end
  end

endmodule

//--- design/flowMuxLruStable.sv
// Top level; sizing only through flowMux_macros.svh, push-to-pop latency is at least 2 edges
`timescale 1ns/1ps
`include "flowMux_macros.svh"

module flowMuxLruStable (
  input  logic                                      clk,
  input  logic                                      reset,
  input  arbCtrlPkg::flowVec_t                      pushValid,
  output arbCtrlPkg::flowVec_t                      pushReady,
  input  flowDataPkg::flowBeat_t [`FLOW_COUNT-1:0]  pushData,
  output logic                                      popValid,
  input  logic                                      popReady,
  output flowDataPkg::popBeat_t                     popBeat
);

  import flowDataPkg::*;
  import arbCtrlPkg::*;

  // ------------------------------
  // Internal links
  // ------------------------------

  flowVec_t                      request;
  flowVec_t                      grant;
  flowVec_t                      headTaken;
  flowBeat_t [`FLOW_COUNT-1:0]   headBeat;
  logic                          grantAccepted;

  // One skid buffer per producer
  for (genvar i = 0; i < `FLOW_COUNT; i++) begin : g_ingress
    flowIngress i_ingress (
      .clk       (clk),
      .reset     (reset),
      .pushValid (pushValid[i]),
      .pushReady (pushReady[i]),
      .pushData  (pushData[i]),
      .headTaken (headTaken[i]),
      .request   (request[i]),
      .headBeat  (headBeat[i])
    );
  end

  // Picks the least recently loaded waiting flow
  lruArbiter i_arbiter (
    .clk           (clk),
    .reset         (reset),
    .request       (request),
    .grant         (grant),
    .grantAccepted (grantAccepted)
  );

  // Mux plus stable output register
  flowMuxCore i_core (
    .clk           (clk),
    .reset         (reset),
    .grant         (grant),
    .headBeat      (headBeat),
    .headTaken     (headTaken),
    .grantAccepted (grantAccepted),
    .popReady      (popReady),
    .popValid      (popValid),
    .popBeat       (popBeat)
  );

endmodule

//--- design/flowMux_macros.svh
// Global sizing shared by all modules; FLOW_ID_WIDTH must be at least 1 and cover FLOW_COUNT
`ifndef FLOW_MUX_MACROS_SVH
`define FLOW_MUX_MACROS_SVH

// ------------------------------
// Subsystem sizing
// ------------------------------

// Number of independent producer flows
`define FLOW_COUNT 4

// Payload width of one beat in bits
`define DATA_WIDTH 16

// Width of the flow number tag on the pop side
// Keep at least 1 even when only one flow exists
`define FLOW_ID_WIDTH 2

`endif

//--- design/lruArbiter.sv
// Grant is combinational from request; priority only moves on grantAccepted, reset order is 0,1,2,3
`timescale 1ns/1ps
`include "flowMux_macros.svh"

module lruArbiter (
  input  logic                clk,
  input  logic                reset,
  input  arbCtrlPkg::flowVec_t request,
  output arbCtrlPkg::flowVec_t grant,
  input  logic                grantAccepted
);

  import arbCtrlPkg::*;

  // ------------------------------
  // Recency state
  // ------------------------------

  // older[i][j] set: flow i used less recently than flow j
  // Matrix is kept antisymmetric, diagonal stays clear
  recencyMatrix_t older;

  // blocked[i] set when some other active requester is older than flow i
  flowVec_t blocked;

  // ------------------------------
  // Grant
  // ------------------------------

  always_comb begin
    blocked = '0;
    for (int i = 0; i < `FLOW_COUNT; i++) begin
      for (int j = 0; j < `FLOW_COUNT; j++) begin
        if (j != i && request[j] && older[j][i]) begin
          blocked[i] = 1'b1;
        end
      end
    end
  end

  // Exactly one active requester is older than all others,
  // so at most one bit survives
  assign grant = request & ~blocked;

  // ------------------------------
  // Recency update
  // ------------------------------

  // Granted flow becomes most recent: its row clears, its column sets
  always_ff @(posedge clk) begin
    if (reset) begin
      older <= resetRecency();
    end else if (grantAccepted) begin
      for (int i = 0; i < `FLOW_COUNT; i++) begin
        for (int j = 0; j < `FLOW_COUNT; j++) begin
          if (i != j) begin
            if (grant[i]) begin
              older[i][j] <= 1'b0;
            end else if (grant[j]) begin
              older[i][j] <= 1'b1;
            end
          end
        end
      end
    end
  end

endmodule

//--- dv/flowMuxLruStableTb.sv
// Directed tests on a 100 ns clock; the model assumes in-order loads and FLOW_COUNT up to 16
`timescale 1ns/1ps
`include "flowMux_macros.svh"

module flowMuxLruStableTb;
  import flowDataPkg::*;
  import arbCtrlPkg::*;

  // ------------------------------
  // Run length budget
  // ------------------------------
  localparam int cyclesReset = 10;
  localparam int cyclesSingle = 30;
  localparam int cyclesLru = 80;
  localparam int cyclesMixed = 60;
  localparam int cyclesBackPressure = 200;
  localparam int cyclesRandom = 400;
  localparam int timeoutCycles = 2 * (2 * cyclesReset + cyclesSingle + cyclesLru
                                      + cyclesMixed + cyclesBackPressure + cyclesRandom);

  logic clk = 1'b0;
  logic reset;
  flowVec_t pushValid;
  flowVec_t pushReady;
  flowBeat_t [`FLOW_COUNT-1:0] pushData;
  logic popValid;
  logic popReady;
  popBeat_t popBeat;

  // Producer queues, model state and counters
  flowBeat_t srcQ[`FLOW_COUNT][$];
  flowBeat_t pendData[`FLOW_COUNT][$];   // pushed, not yet loaded
  int lruOrder[$];                       // front is least recently used
  int seqNo[`FLOW_COUNT];
  popBeat_t popLog[$];
  popBeat_t regBeat;
  logic regValid = 1'b0;
  flowVec_t pushFireNext = '0;
  bit pushRandom = 1'b0;
  bit popRandom = 1'b0;
  bit popHold = 1'b0;
  logic [31:0] lfsrState = 32'hd6e372f7;
  int errorCount = 0;
  int testCount = 0;
  int pushCount = 0;
  int popCount = 0;
  int cycleCount = 0;

  flowMuxLruStable i_dut (
    .clk(clk), .reset(reset), .pushValid(pushValid), .pushReady(pushReady),
    .pushData(pushData), .popValid(popValid), .popReady(popReady), .popBeat(popBeat)
  );

  always #50 clk = ~clk;

  initial begin
    reset = 1'b1;
    pushValid = '0;
    pushData = '0;
    popReady = 1'b0;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic nextBit();
    logic lsb;
    lsb = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (lsb) lfsrState = lfsrState ^ 32'h80200003;
    return lsb;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[30:0], nextBit()};
    return v;
  endfunction

  // Flow number in the top nibble, sequence number below
  function automatic flowBeat_t beatData(input int f, input int n);
    return flowBeat_t'({4'(f), 12'(n)});
  endfunction

  function automatic flowVec_t expectedReady();
    flowVec_t r;
    for (int f = 0; f < `FLOW_COUNT; f++) r[f] = (pendData[f].size() < 2);
    return r;
  endfunction

  function automatic void markUsed(input int f);
    int idx;
    idx = 0;
    foreach (lruOrder[k]) if (lruOrder[k] == f) idx = k;
    lruOrder.delete(idx);
    lruOrder.push_back(f);
  endfunction

  function automatic void resetModel();
    regValid = 1'b0;
    lruOrder.delete();
    for (int f = 0; f < `FLOW_COUNT; f++) begin
      pendData[f].delete();
      lruOrder.push_back(f);
    end
  endfunction

  function automatic bit isIdle();
    bit idle;
    idle = !regValid;
    for (int f = 0; f < `FLOW_COUNT; f++)
      if (srcQ[f].size() != 0 || pendData[f].size() != 0) idle = 1'b0;
    return idle;
  endfunction

  task automatic comparePopBeat(input string name, input popBeat_t got, input popBeat_t exp);
    if (got !== exp) begin
      errorCount++;
      $display("ERROR %0t %s got flowId %0d data %h, expected flowId %0d data %h",
               $time, name, got.flowId, got.data, exp.flowId, exp.data);
    end
  endtask

  task automatic compareFlowVec(input string name, input flowVec_t got, input flowVec_t exp);
    if (got !== exp) begin
      errorCount++;
      $display("ERROR %0t %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compareValid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errorCount++;
      $display("ERROR %0t %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compareCount(input string name, input int got, input int exp);
    if (got != exp) begin
      errorCount++;
      $display("ERROR %0t %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  // ------------------------------
  // Driver and reference model
  // ------------------------------
  // Valid and data hold until the handshake seen at the last falling edge
  always @(posedge clk) begin
    logic keep;
    for (int f = 0; f < `FLOW_COUNT; f++) begin
      if (pushFireNext[f]) void'(srcQ[f].pop_front());
      keep = pushValid[f] && !pushFireNext[f];
      if (!keep) begin
        if (srcQ[f].size() > 0 && (!pushRandom || nextBit())) begin
          pushValid[f] <= 1'b1;
          pushData[f] <= srcQ[f][0];
        end else begin
          pushValid[f] <= 1'b0;
        end
      end
    end
    if (popRandom) popReady <= nextBit();
    else popReady <= !popHold;
  end

  // Samples settled values and predicts the next rising edge
  always @(negedge clk) begin
    int pick;
    cycleCount++;
    if (cycleCount > timeoutCycles) begin
      errorCount++;
      $display("Run stopped: no finish within %0d cycles", timeoutCycles);
      finishRun();
    end else if (reset) begin
      pushFireNext = '0;
      resetModel();
    end else begin
      pushFireNext = pushValid & pushReady;
      compareFlowVec("pushReady", pushReady, expectedReady());
      compareValid("popValid", popValid, regValid);
      if (regValid && popValid) comparePopBeat("popBeat", popBeat, regBeat);
      if (popValid && popReady) begin
        popCount++;
        popLog.push_back(popBeat);
      end
      // Free register takes the least recently used waiting flow
      if (!regValid || popReady) begin
        pick = -1;
        foreach (lruOrder[k])
          if (pick < 0 && pendData[lruOrder[k]].size() > 0) pick = lruOrder[k];
        regValid = (pick >= 0);
        if (pick >= 0) begin
          regBeat.flowId = flowId_t'(pick);
          regBeat.data = pendData[pick].pop_front();
          markUsed(pick);
        end
      end
      // New beats request from the edge after their push
      for (int f = 0; f < `FLOW_COUNT; f++) begin
        if (pushFireNext[f]) begin
          pendData[f].push_back(pushData[f]);
          pushCount++;
        end
      end
    end
  end

  // ------------------------------
  // Test steps
  // ------------------------------
  // Reset held for 4 rising edges
  task automatic resetDut();
    @(posedge clk);
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic setTraffic(input bit pushRnd, input bit popRnd, input bit hold);
    @(negedge clk);
    pushRandom = pushRnd;
    popRandom = popRnd;
    popHold = hold;
  endtask

  task automatic loadFlow(input int f, input int count, input bit randomData);
    for (int n = 0; n < count; n++) begin
      if (randomData) srcQ[f].push_back(flowBeat_t'(randBits(16)));
      else srcQ[f].push_back(beatData(f, seqNo[f]));
      seqNo[f]++;
    end
  endtask

  task automatic waitDrained(input string name, input int limit);
    int n;
    n = 0;
    @(posedge clk);
    while (!isIdle() && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!isIdle()) begin
      errorCount++;
      $display("%s: traffic did not drain within %0d cycles", name, limit);
    end
  endtask

  task automatic reportTest(input string name, input int startErrors);
    testCount++;
    $display("%s: %s, %0d errors", name, (errorCount == startErrors) ? "pass" : "fail",
             errorCount - startErrors);
  endtask

  task automatic finishRun();
    $display("Summary: %0d tests, %0d pushes, %0d pops, %0d errors",
             testCount, pushCount, popCount, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic testReset();
    int startErrors;
    startErrors = errorCount;
    resetDut();
    @(negedge clk);
    compareFlowVec("pushReady", pushReady, '1);
    compareValid("popValid", popValid, 1'b0);
    reportTest("reset", startErrors);
  endtask

  task automatic testSingleFlow();
    int startErrors;
    int base;
    int start;
    popBeat_t exp;
    startErrors = errorCount;
    base = popLog.size();
    start = seqNo[2];
    @(negedge clk);
    loadFlow(2, 8, 1'b0);
    waitDrained("single flow", cyclesSingle);
    compareCount("single flow pops", popLog.size() - base, 8);
    for (int k = 0; k < 8 && base + k < popLog.size(); k++) begin
      exp.flowId = flowId_t'(2);
      exp.data = beatData(2, start + k);
      comparePopBeat("popBeat", popLog[base + k], exp);
    end
    reportTest("single flow", startErrors);
  endtask

  // Reset order gives 0, 1, 2, 3 repeating with every flow waiting
  task automatic testLruContention();
    int startErrors;
    int base;
    int f;
    int start[`FLOW_COUNT];
    popBeat_t exp;
    startErrors = errorCount;
    resetDut();
    base = popLog.size();
    @(negedge clk);
    for (int i = 0; i < `FLOW_COUNT; i++) begin
      start[i] = seqNo[i];
      loadFlow(i, 12, 1'b0);
    end
    waitDrained("lru contention", cyclesLru);
    compareCount("lru contention pops", popLog.size() - base, 12 * `FLOW_COUNT);
    for (int k = 0; k < 12 * `FLOW_COUNT && base + k < popLog.size(); k++) begin
      f = k % `FLOW_COUNT;
      exp.flowId = flowId_t'(f);
      exp.data = beatData(f, start[f] + k / `FLOW_COUNT);
      comparePopBeat("popBeat", popLog[base + k], exp);
    end
    reportTest("lru contention", startErrors);
  endtask

  // Staggered starts behind a held pop side
  task automatic testMixedRecency();
    int startErrors;
    int base;
    startErrors = errorCount;
    base = popLog.size();
    setTraffic(1'b0, 1'b0, 1'b1);
    loadFlow(3, 4, 1'b0);
    repeat (3) @(negedge clk);
    loadFlow(1, 4, 1'b0);
    repeat (2) @(negedge clk);
    loadFlow(0, 4, 1'b0);
    repeat (4) @(negedge clk);
    loadFlow(2, 4, 1'b0);
    repeat (3) @(negedge clk);
    popHold = 1'b0;
    waitDrained("mixed recency", cyclesMixed);
    compareCount("mixed recency pops", popLog.size() - base, 16);
    reportTest("mixed recency", startErrors);
  endtask

  task automatic testBackPressure();
    int startErrors;
    int base;
    flowVec_t expReady;
    startErrors = errorCount;
    base = popLog.size();
    setTraffic(1'b0, 1'b0, 1'b1);
    loadFlow(1, 4, 1'b0);
    repeat (8) @(negedge clk);
    // One beat in the output register, two waiting in flow 1
    expReady = '1;
    expReady[1] = 1'b0;
    compareFlowVec("pushReady", pushReady, expReady);
    popHold = 1'b0;
    popRandom = 1'b1;
    for (int i = 0; i < `FLOW_COUNT; i++) loadFlow(i, 10, 1'b0);
    waitDrained("back-pressure", cyclesBackPressure);
    setTraffic(1'b0, 1'b0, 1'b0);
    compareCount("back-pressure pops", popLog.size() - base, 4 + 10 * `FLOW_COUNT);
    reportTest("back-pressure", startErrors);
  endtask

  task automatic testRandom();
    int startErrors;
    int base;
    int want[`FLOW_COUNT];
    int got[`FLOW_COUNT];
    startErrors = errorCount;
    base = popLog.size();
    setTraffic(1'b1, 1'b1, 1'b0);
    for (int i = 0; i < `FLOW_COUNT; i++) begin
      want[i] = 5 + int'(randBits(4));
      got[i] = 0;
      loadFlow(i, want[i], 1'b1);
    end
    waitDrained("random traffic", cyclesRandom);
    setTraffic(1'b0, 1'b0, 1'b0);
    for (int k = base; k < popLog.size(); k++) got[popLog[k].flowId]++;
    for (int i = 0; i < `FLOW_COUNT; i++)
      compareCount($sformatf("flow %0d pops", i), got[i], want[i]);
    reportTest("random traffic", startErrors);
  endtask

  initial begin
    testReset();
    testSingleFlow();
    testLruContention();
    testMixedRecency();
    testBackPressure();
    testRandom();
    compareCount("total pops against pushes", popCount, pushCount);
    finishRun();
  end

endmodule

//--- dv/flowMuxLruStable_sva.sv
// Bound to flowMuxLruStable; all checks are off during reset and pushValid hold is a producer rule
`timescale 1ns/1ps
`include "flowMux_macros.svh"

module flowMuxLruStable_sva (
  input logic                  clk,
  input logic                  reset,
  input arbCtrlPkg::flowVec_t  pushValid,
  input arbCtrlPkg::flowVec_t  pushReady,
  input arbCtrlPkg::flowVec_t  grant,
  input logic                  popValid,
  input logic                  popReady,
  input flowDataPkg::popBeat_t popBeat
);

  // Stalled output keeps valid and the whole tagged beat
  assertPopStable: assert property (@(posedge clk) disable iff (reset)
    popValid && !popReady |=> popValid && $stable(popBeat))
    else $error("popBeat or popValid changed while the pop side was stalled");

  // Arbiter never grants two flows at once
  assertGrantOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
    else $error("arbiter grant is not one-hot or zero");

  // A waiting producer keeps valid up until its transfer
  for (genvar i = 0; i < `FLOW_COUNT; i++) begin : g_pushHold
    assertPushHold: assert property (@(posedge clk) disable iff (reset)
      pushValid[i] && !pushReady[i] |=> pushValid[i])
      else $error("pushValid on flow %0d dropped before its ready", i);
  end

endmodule

// Grant is internal to the top level and reached through the bind scope
bind flowMuxLruStable flowMuxLruStable_sva i_sva (
  .clk       (clk),
  .reset     (reset),
  .pushValid (pushValid),
  .pushReady (pushReady),
  .grant     (grant),
  .popValid  (popValid),
  .popReady  (popReady),
  .popBeat   (popBeat)
);

//--- src.f
+incdir+design
design/flowDataPkg.sv
design/arbCtrlPkg.sv
design/flowIngress.sv
design/lruArbiter.sv
design/flowMuxCore.sv
design/flowMuxLruStable.sv
dv/flowMuxLruStable_sva.sv
dv/flowMuxLruStableTb.sv
